/* Makefile */
TOP = tb_matrix_op_executor

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --top-module $(TOP) -f compile.f --Mdir obj_dir -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir

/* compile.f */
matrix_types_pkg.sv
matrix_op_pkg.sv
operand_fetch.sv
result_fifo.sv
result_writer.sv
op_sequencer.sv
matrix_op_executor.sv
matrix_store_model.sv
tb_matrix_op_executor.sv

/* matrix_op_executor.sv */
`timescale 1ns/1ps

module matrix_op_executor #(
    parameter  int BLOCK_SIZE     = matrix_types_pkg::DEFAULT_BLOCK_SIZE,
    parameter  int SCALAR_TEMP_ID = 7,
    parameter  int RESULT_ID      = 6,
    parameter  int FIFO_DEPTH     = 4,
    localparam int ADDR_WIDTH     = matrix_types_pkg::addr_width(BLOCK_SIZE)
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  matrix_op_pkg::calc_type_t    op_type,
    input  matrix_types_pkg::matrix_id_t matrix_a,
    input  matrix_types_pkg::matrix_id_t matrix_b,
    input  matrix_types_pkg::data_t      scalar_in,
    output logic                         busy,
    output logic                         done,
    output logic [ADDR_WIDTH-1:0]        bram_read_addr,
    input  matrix_types_pkg::data_t      bram_data_out,
    output logic                         write_request,
    input  logic                         write_ready,
    output matrix_types_pkg::matrix_id_t write_matrix_id,
    output matrix_types_pkg::dim_t       write_rows,
    output matrix_types_pkg::dim_t       write_cols,
    output matrix_types_pkg::data_t      write_data,
    output logic                         write_data_valid,
    input  logic                         writer_ready,
    input  logic                         write_done
);

    // Sequencer to fetch and writer
    logic                         fetch_start;
    matrix_op_pkg::calc_type_t    fetch_op;
    matrix_types_pkg::matrix_id_t fetch_a;
    matrix_types_pkg::matrix_id_t fetch_b;
    logic                         writer_start;
    logic                         writer_prelude;
    matrix_types_pkg::data_t      prelude_scalar;
    logic                         writer_finished;

    // Result path through the FIFO
    logic                         push;
    matrix_types_pkg::data_t      push_data;
    logic                         full;
    logic                         pop;
    matrix_types_pkg::data_t      pop_data;
    logic                         not_empty;

    op_sequencer op_sequencer_i (.*);

    operand_fetch #(
        .BLOCK_SIZE    (BLOCK_SIZE),
        .SCALAR_TEMP_ID(SCALAR_TEMP_ID)
    ) operand_fetch_i (.*);

    result_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) result_fifo_i (.*);

    result_writer #(
        .BLOCK_SIZE    (BLOCK_SIZE),
        .RESULT_ID     (RESULT_ID),
        .SCALAR_TEMP_ID(SCALAR_TEMP_ID)
    ) result_writer_i (.*);

endmodule

/* matrix_op_pkg.sv */
package matrix_op_pkg;

    // Code 2'b11 is unused and runs as add
    typedef enum logic [1:0] {
        CALC_ADD        = 2'd0,
        CALC_SCALAR_MUL = 2'd1,
        CALC_TRANSPOSE  = 2'd2
    } calc_type_t;

    // Sequencer phases
    typedef enum logic [2:0] {
        SEQ_IDLE         = 3'd0,
        SEQ_PRELUDE      = 3'd1,
        SEQ_PRELUDE_WAIT = 3'd2,
        SEQ_LAUNCH       = 3'd3,
        SEQ_EXECUTE      = 3'd4
    } seq_state_t;

endpackage

/* matrix_store_model.sv */
`timescale 1ns/1ps

module matrix_store_model #(
    parameter int BLOCK_SIZE = 4,
    parameter int ADDR_WIDTH = 7
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [ADDR_WIDTH-1:0]        bram_read_addr,
    output matrix_types_pkg::data_t      bram_data_out,
    input  logic                         write_request,
    output logic                         write_ready,
    input  matrix_types_pkg::matrix_id_t write_matrix_id,
    input  matrix_types_pkg::dim_t       write_rows,
    input  matrix_types_pkg::dim_t       write_cols,
    input  matrix_types_pkg::data_t      write_data,
    input  logic                         write_data_valid,
    output logic                         writer_ready,
    output logic                         write_done,
    input  logic                         hold_off,
    input  logic                         load_en,
    input  logic [ADDR_WIDTH-1:0]        load_addr,
    input  matrix_types_pkg::data_t      load_data
);

    localparam int WORDS = 2 ** ADDR_WIDTH;

    matrix_types_pkg::data_t mem [WORDS];
    logic                    in_write;
    logic                    accepting;
    int                      beat_row;
    int                      beat_col;
    int                      beat_count;
    logic                    beat;
    logic [ADDR_WIDTH-1:0]   waddr;

    assign write_ready  = !in_write;
    assign writer_ready = accepting && !hold_off;
    assign beat         = accepting && write_data_valid && !hold_off;
    // Row-major beats land inside an N-wide slot
    assign waddr = ADDR_WIDTH'((int'(write_matrix_id) * BLOCK_SIZE + beat_row) * BLOCK_SIZE
                               + beat_col);

    always @(posedge clk) begin
        bram_data_out <= mem[bram_read_addr];
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
        if (beat) begin
            mem[waddr] <= write_data;
        end
    end

    // ----------------------------------------
    // Write handshake
    // ----------------------------------------
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_write   <= 1'b0;
            accepting  <= 1'b0;
            write_done <= 1'b0;
            beat_row   <= 0;
            beat_col   <= 0;
            beat_count <= 0;
        end else begin
            write_done <= 1'b0;
            if (!in_write && write_request) begin
                in_write  <= 1'b1;
                accepting <= 1'b1;
                beat_row  <= 0;
                beat_col  <= 0;
            end
            if (beat) begin
                beat_count <= beat_count + 1;
                if (beat_col == int'(write_cols) - 1) begin
                    beat_col <= 0;
                    beat_row <= beat_row + 1;
                    // Last beat, done follows one cycle later
                    if (beat_row == int'(write_rows) - 1) begin
                        accepting  <= 1'b0;
                        write_done <= 1'b1;
                    end
                end else begin
                    beat_col <= beat_col + 1;
                end
            end
            if (write_done) begin
                in_write <= 1'b0;
            end
        end
    end

endmodule

/* matrix_types_pkg.sv */
package matrix_types_pkg;

    // Eight matrix slots
    localparam int MATRIX_ID_WIDTH = 3;
    typedef logic [MATRIX_ID_WIDTH-1:0] matrix_id_t;

    localparam int MATRIX_DATA_WIDTH = 32;
    typedef logic [MATRIX_DATA_WIDTH-1:0] data_t;

    // Square matrices, N x N
    localparam int DEFAULT_BLOCK_SIZE = 4;
    localparam int DIM_WIDTH = 8;
    typedef logic [DIM_WIDTH-1:0] dim_t;

    // Address bits covering every slot
    function automatic int addr_width(int block_size);
        return $clog2((2 ** MATRIX_ID_WIDTH) * block_size * block_size);
    endfunction

    // Slot first, then row-major inside the slot
    function automatic int elem_addr(int id, int row, int col, int block_size);
        return (id * block_size + row) * block_size + col;
    endfunction

endpackage

/* op_sequencer.sv */
`timescale 1ns/1ps

module op_sequencer (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  matrix_op_pkg::calc_type_t    op_type,
    input  matrix_types_pkg::matrix_id_t matrix_a,
    input  matrix_types_pkg::matrix_id_t matrix_b,
    input  matrix_types_pkg::data_t      scalar_in,
    input  logic                         write_ready,
    output logic                         busy,
    output logic                         done,
    output logic                         fetch_start,
    output matrix_op_pkg::calc_type_t    fetch_op,
    output matrix_types_pkg::matrix_id_t fetch_a,
    output matrix_types_pkg::matrix_id_t fetch_b,
    output logic                         writer_start,
    output logic                         writer_prelude,
    output matrix_types_pkg::data_t      prelude_scalar,
    input  logic                         writer_finished
);

    matrix_op_pkg::seq_state_t state;

    assign busy = (state != matrix_op_pkg::SEQ_IDLE);

    // Operation request held for the whole run
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            fetch_op       <= op_type;
            fetch_a        <= matrix_a;
            fetch_b        <= matrix_b;
            prelude_scalar <= scalar_in;
        end
    end

    // ----------------------------------------
    // Phase control
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= matrix_op_pkg::SEQ_IDLE;
            done           <= 1'b0;
            fetch_start    <= 1'b0;
            writer_start   <= 1'b0;
            writer_prelude <= 1'b0;
        end else begin
            done         <= 1'b0;
            fetch_start  <= 1'b0;
            writer_start <= 1'b0;
            case (state)
                matrix_op_pkg::SEQ_IDLE: begin
                    if (start) begin
                        if (op_type == matrix_op_pkg::CALC_SCALAR_MUL) begin
                            state <= matrix_op_pkg::SEQ_PRELUDE;
                        end else begin
                            state <= matrix_op_pkg::SEQ_LAUNCH;
                        end
                    end
                end
                // Scalar goes to its temp slot first
                matrix_op_pkg::SEQ_PRELUDE: begin
                    if (write_ready) begin
                        writer_start   <= 1'b1;
                        writer_prelude <= 1'b1;
                        state          <= matrix_op_pkg::SEQ_PRELUDE_WAIT;
                    end
                end
                matrix_op_pkg::SEQ_PRELUDE_WAIT: begin
                    if (writer_finished) begin
                        state <= matrix_op_pkg::SEQ_LAUNCH;
                    end
                end
                matrix_op_pkg::SEQ_LAUNCH: begin
                    if (write_ready) begin
                        fetch_start    <= 1'b1;
                        writer_start   <= 1'b1;
                        writer_prelude <= 1'b0;
                        state          <= matrix_op_pkg::SEQ_EXECUTE;
                    end
                end
                matrix_op_pkg::SEQ_EXECUTE: begin
                    if (writer_finished) begin
                        done  <= 1'b1;
                        state <= matrix_op_pkg::SEQ_IDLE;
                    end
                end
                default: state <= matrix_op_pkg::SEQ_IDLE;
            endcase
        end
    end

endmodule

/* operand_fetch.sv */
`timescale 1ns/1ps

module operand_fetch #(
    parameter  int BLOCK_SIZE     = matrix_types_pkg::DEFAULT_BLOCK_SIZE,
    parameter  int SCALAR_TEMP_ID = 7,
    localparam int ADDR_WIDTH     = matrix_types_pkg::addr_width(BLOCK_SIZE)
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         fetch_start,
    input  matrix_op_pkg::calc_type_t    fetch_op,
    input  matrix_types_pkg::matrix_id_t fetch_a,
    input  matrix_types_pkg::matrix_id_t fetch_b,
    output logic [ADDR_WIDTH-1:0]        bram_read_addr,
    input  matrix_types_pkg::data_t      bram_data_out,
    output logic                         push,
    output matrix_types_pkg::data_t      push_data,
    input  logic                         full
);

    localparam matrix_types_pkg::dim_t LAST = matrix_types_pkg::dim_t'(BLOCK_SIZE - 1);

    // What the word returning next cycle is for
    typedef enum logic [1:0] {
        TAG_SCALAR,
        TAG_OPERAND_A,
        TAG_RESULT
    } tag_t;

    logic                    active;
    logic                    scalar_phase;
    logic                    second_read;
    matrix_types_pkg::dim_t  row;
    matrix_types_pkg::dim_t  col;
    logic                    is_add;
    logic                    issue;
    int                      read_addr;
    tag_t                    issue_tag;
    logic                    tag_valid;
    tag_t                    tag;
    matrix_types_pkg::data_t scalar_q;
    matrix_types_pkg::data_t operand_a_q;

    assign is_add = (fetch_op != matrix_op_pkg::CALC_SCALAR_MUL) &&
                    (fetch_op != matrix_op_pkg::CALC_TRANSPOSE);
    assign issue  = active && !full;

    // ----------------------------------------
    // Read address generation
    // ----------------------------------------
    always_comb begin
        if (scalar_phase) begin
            read_addr = matrix_types_pkg::elem_addr(SCALAR_TEMP_ID, 0, 0, BLOCK_SIZE);
            issue_tag = TAG_SCALAR;
        end else if (fetch_op == matrix_op_pkg::CALC_TRANSPOSE) begin
            read_addr = matrix_types_pkg::elem_addr(fetch_a, col, row, BLOCK_SIZE);
            issue_tag = TAG_RESULT;
        end else if (is_add && second_read) begin
            read_addr = matrix_types_pkg::elem_addr(fetch_b, row, col, BLOCK_SIZE);
            issue_tag = TAG_RESULT;
        end else begin
            read_addr = matrix_types_pkg::elem_addr(fetch_a, row, col, BLOCK_SIZE);
            issue_tag = is_add ? TAG_OPERAND_A : TAG_RESULT;
        end
    end

    assign bram_read_addr = ADDR_WIDTH'(read_addr);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active       <= 1'b0;
            scalar_phase <= 1'b0;
            second_read  <= 1'b0;
            row          <= '0;
            col          <= '0;
        end else if (fetch_start) begin
            active       <= 1'b1;
            scalar_phase <= (fetch_op == matrix_op_pkg::CALC_SCALAR_MUL);
            second_read  <= 1'b0;
            row          <= '0;
            col          <= '0;
        end else if (issue) begin
            if (scalar_phase) begin
                scalar_phase <= 1'b0;
            end else if (is_add && !second_read) begin
                second_read <= 1'b1;
            end else begin
                second_read <= 1'b0;
                if (col == LAST) begin
                    col <= '0;
                    row <= row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
                // Last element issued
                if (row == LAST && col == LAST) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // ----------------------------------------
    // Returning data and result
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag_valid <= 1'b0;
            push      <= 1'b0;
        end else begin
            tag_valid <= issue;
            push      <= tag_valid && (tag == TAG_RESULT);
        end
    end

    always_ff @(posedge clk) begin
        tag <= issue_tag;
        if (tag_valid) begin
            case (tag)
                TAG_SCALAR:    scalar_q    <= bram_data_out;
                TAG_OPERAND_A: operand_a_q <= bram_data_out;
                default: begin
                    if (is_add) begin
                        push_data <= operand_a_q + bram_data_out;
                    end else if (fetch_op == matrix_op_pkg::CALC_SCALAR_MUL) begin
                        push_data <= bram_data_out * scalar_q;
                    end else begin
                        push_data <= bram_data_out;
                    end
                end
            endcase
        end
    end

endmodule

/* result_fifo.sv */
`timescale 1ns/1ps

module result_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    push,
    input  matrix_types_pkg::data_t push_data,
    output logic                    full,
    input  logic                    pop,
    output matrix_types_pkg::data_t pop_data,
    output logic                    not_empty
);

    // Results still in the fetch pipeline when full rises
    localparam int IN_FLIGHT = 3;
    localparam int PTR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    matrix_types_pkg::data_t mem [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0]    wr_ptr;
    logic [PTR_WIDTH-1:0]    rd_ptr;
    logic [CNT_WIDTH-1:0]    count;
    logic                    do_push;
    logic                    do_pop;

    assign not_empty = (count != '0);
    assign full      = (count >= CNT_WIDTH'(FIFO_DEPTH - IN_FLIGHT));
    assign pop_data  = mem[rd_ptr];
    assign do_push   = push && (count != CNT_WIDTH'(FIFO_DEPTH));
    assign do_pop    = pop && not_empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* result_writer.sv */
`timescale 1ns/1ps

module result_writer #(
    parameter int BLOCK_SIZE     = matrix_types_pkg::DEFAULT_BLOCK_SIZE,
    parameter int RESULT_ID      = 6,
    parameter int SCALAR_TEMP_ID = 7
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         writer_start,
    input  logic                         writer_prelude,
    input  matrix_types_pkg::data_t      prelude_scalar,
    output logic                         pop,
    input  matrix_types_pkg::data_t      pop_data,
    input  logic                         not_empty,
    output logic                         write_request,
    input  logic                         write_ready,
    output matrix_types_pkg::matrix_id_t write_matrix_id,
    output matrix_types_pkg::dim_t       write_rows,
    output matrix_types_pkg::dim_t       write_cols,
    output matrix_types_pkg::data_t      write_data,
    output logic                         write_data_valid,
    input  logic                         writer_ready,
    input  logic                         write_done,
    output logic                         writer_finished
);

    localparam int BEATS_WIDTH = $clog2(BLOCK_SIZE * BLOCK_SIZE + 1);

    typedef enum logic [2:0] {
        W_IDLE,
        W_REQUEST,
        W_GRANT,
        W_DATA,
        W_FINISH
    } writer_state_t;

    writer_state_t          state;
    logic                   prelude_q;
    logic [BEATS_WIDTH-1:0] beats_left;
    logic                   beat;

    // Prelude sends its single scalar, otherwise FIFO data
    assign write_data_valid = (state == W_DATA) && (prelude_q || not_empty);
    assign write_data       = prelude_q ? prelude_scalar : pop_data;
    assign beat             = write_data_valid && writer_ready;
    assign pop              = beat && !prelude_q;
    assign writer_finished  = (state == W_FINISH) && write_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= W_IDLE;
            write_request <= 1'b0;
            prelude_q     <= 1'b0;
            beats_left    <= '0;
        end else begin
            case (state)
                W_IDLE: begin
                    if (writer_start) begin
                        prelude_q  <= writer_prelude;
                        beats_left <= writer_prelude ? BEATS_WIDTH'(1) :
                                      BEATS_WIDTH'(BLOCK_SIZE * BLOCK_SIZE);
                        state      <= W_REQUEST;
                    end
                end
                W_REQUEST: begin
                    if (write_ready) begin
                        write_request <= 1'b1;
                        state         <= W_GRANT;
                    end
                end
                // Request held until the storage side answers
                W_GRANT: begin
                    if (writer_ready) begin
                        write_request <= 1'b0;
                        state         <= W_DATA;
                    end
                end
                W_DATA: begin
                    if (beat) begin
                        beats_left <= beats_left - 1'b1;
                        if (beats_left == BEATS_WIDTH'(1)) begin
                            state <= W_FINISH;
                        end
                    end
                end
                W_FINISH: begin
                    if (write_done) begin
                        state <= W_IDLE;
                    end
                end
                default: state <= W_IDLE;
            endcase
        end
    end

    // Metadata stable from request to write_done
    always_ff @(posedge clk) begin
        if (state == W_IDLE && writer_start) begin
            if (writer_prelude) begin
                write_matrix_id <= matrix_types_pkg::matrix_id_t'(SCALAR_TEMP_ID);
                write_rows      <= matrix_types_pkg::dim_t'(1);
                write_cols      <= matrix_types_pkg::dim_t'(1);
            end else begin
                write_matrix_id <= matrix_types_pkg::matrix_id_t'(RESULT_ID);
                write_rows      <= matrix_types_pkg::dim_t'(BLOCK_SIZE);
                write_cols      <= matrix_types_pkg::dim_t'(BLOCK_SIZE);
            end
        end
    end

endmodule

/* tb_matrix_op_executor.sv */
`timescale 1ns/1ps

module tb_matrix_op_executor;

    localparam int BLOCK_SIZE     = 4;
    localparam int SCALAR_TEMP_ID = 7;
    localparam int RESULT_ID      = 6;
    localparam int ADDR_WIDTH     = $clog2(8 * BLOCK_SIZE * BLOCK_SIZE);
    localparam int WORDS          = 2 ** ADDR_WIDTH;
    localparam int RUN_TIMEOUT    = 2000;

    logic                         clk = 1'b0;
    logic                         rst_n;
    logic                         start;
    matrix_op_pkg::calc_type_t    op_type;
    matrix_types_pkg::matrix_id_t matrix_a;
    matrix_types_pkg::matrix_id_t matrix_b;
    matrix_types_pkg::data_t      scalar_in;
    logic                         busy;
    logic                         done;
    logic [ADDR_WIDTH-1:0]        bram_read_addr;
    matrix_types_pkg::data_t      bram_data_out;
    logic                         write_request;
    logic                         write_ready;
    matrix_types_pkg::matrix_id_t write_matrix_id;
    matrix_types_pkg::dim_t       write_rows;
    matrix_types_pkg::dim_t       write_cols;
    matrix_types_pkg::data_t      write_data;
    logic                         write_data_valid;
    logic                         writer_ready;
    logic                         write_done;
    logic                         hold_off;
    logic                         load_en;
    logic [ADDR_WIDTH-1:0]        load_addr;
    matrix_types_pkg::data_t      load_data;

    logic [31:0]                  lfsr = 32'hd4e021fb;
    logic [3:0]                   stall_level;
    int                           done_count = 0;

    // Operation under test and memory copy taken at its start
    matrix_op_pkg::calc_type_t    cur_op;
    matrix_types_pkg::matrix_id_t cur_a;
    matrix_types_pkg::matrix_id_t cur_b;
    matrix_types_pkg::data_t      cur_scalar;
    matrix_types_pkg::data_t      snap [WORDS];

    matrix_op_executor #(
        .BLOCK_SIZE    (BLOCK_SIZE),
        .SCALAR_TEMP_ID(SCALAR_TEMP_ID),
        .RESULT_ID     (RESULT_ID),
        .FIFO_DEPTH    (4)
    ) matrix_op_executor_i (.*);

    matrix_store_model #(
        .BLOCK_SIZE(BLOCK_SIZE),
        .ADDR_WIDTH(ADDR_WIDTH)
    ) store_model_i (.*);

    initial begin
        forever #20 clk = ~clk;
    end

    // ----------------------------------------
    // Random numbers and reference
    // ----------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] draw_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] slot_addr(input int id, input int r, input int c);
        return ADDR_WIDTH'(id * BLOCK_SIZE * BLOCK_SIZE + r * BLOCK_SIZE + c);
    endfunction

    // Unused code 3 behaves as add
    function automatic matrix_types_pkg::data_t expected_elem(input int r, input int c);
        case (cur_op)
            matrix_op_pkg::CALC_SCALAR_MUL: return snap[slot_addr(int'(cur_a), r, c)] * cur_scalar;
            matrix_op_pkg::CALC_TRANSPOSE:  return snap[slot_addr(int'(cur_a), c, r)];
            default: return snap[slot_addr(int'(cur_a), r, c)] + snap[slot_addr(int'(cur_b), r, c)];
        endcase
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("Error at %0d ns: %s is %h, expected %h",
                                $time, what, got, expected));
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        hold_off = (4'(draw_bits(4)) < stall_level);
    endtask

    task automatic compare_result();
        for (int r = 0; r < BLOCK_SIZE; r++) begin
            for (int c = 0; c < BLOCK_SIZE; c++) begin
                check_value($sformatf("result element (%0d,%0d)", r, c),
                            store_model_i.mem[slot_addr(RESULT_ID, r, c)], expected_elem(r, c));
            end
        end
        if (cur_op == matrix_op_pkg::CALC_SCALAR_MUL) begin
            check_value("scalar temp slot", store_model_i.mem[slot_addr(SCALAR_TEMP_ID, 0, 0)],
                        cur_scalar);
        end
    endtask

    // Result check on every done pulse
    always @(negedge clk) begin
        if (rst_n && done) begin
            done_count = done_count + 1;
            compare_result();
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic preload_memory();
        for (int i = 0; i < WORDS; i++) begin
            load_en   = 1'b1;
            load_addr = ADDR_WIDTH'(i);
            load_data = (i < 4 * BLOCK_SIZE * BLOCK_SIZE) ? draw_bits(32) : (32'h5eed_0000 | 32'(i));
            // Nothing moves before the first start
            check_value("busy before start", 32'(busy), 32'd0);
            check_value("done before start", 32'(done), 32'd0);
            check_value("write_request before start", 32'(write_request), 32'd0);
            check_value("write_data_valid before start", 32'(write_data_valid), 32'd0);
            next_cycle();
        end
        load_en = 1'b0;
    endtask

    task automatic run_op(input matrix_op_pkg::calc_type_t op, input int a, input int b,
                          input matrix_types_pkg::data_t scalar, input bit retrigger);
        int cycles;
        int dones_before;
        int beats_before;
        int beats_expected;
        cur_op         = op;
        cur_a          = matrix_types_pkg::matrix_id_t'(a);
        cur_b          = matrix_types_pkg::matrix_id_t'(b);
        cur_scalar     = scalar;
        snap           = store_model_i.mem;
        dones_before   = done_count;
        beats_before   = store_model_i.beat_count;
        beats_expected = BLOCK_SIZE * BLOCK_SIZE + ((op == matrix_op_pkg::CALC_SCALAR_MUL) ? 1 : 0);
        start     = 1'b1;
        op_type   = op;
        matrix_a  = cur_a;
        matrix_b  = cur_b;
        scalar_in = scalar;
        next_cycle();
        start  = 1'b0;
        cycles = 0;
        while (!done) begin
            check_value("busy during operation", 32'(busy), 32'd1);
            // Stray strobe with other operands while busy
            start = retrigger && (cycles == 3);
            if (start) begin
                op_type   = matrix_op_pkg::CALC_TRANSPOSE;
                matrix_a  = matrix_types_pkg::matrix_id_t'(5);
                scalar_in = ~scalar;
            end
            cycles++;
            if (cycles > RUN_TIMEOUT) begin
                abort_run($sformatf("Timed out after %0d cycles waiting for done, sequencer in %s",
                                    cycles, matrix_op_executor_i.op_sequencer_i.state.name()));
            end
            next_cycle();
        end
        start = 1'b0;
        next_cycle();
        check_value("done after its pulse", 32'(done), 32'd0);
        check_value("busy after done", 32'(busy), 32'd0);
        check_value("done pulses", 32'(done_count - dones_before), 32'd1);
        check_value("accepted beats", 32'(store_model_i.beat_count - beats_before),
                    32'(beats_expected));
    endtask

    task automatic run_random_ops(input int count);
        matrix_op_pkg::calc_type_t op;
        int                        src_a;
        int                        src_b;
        matrix_types_pkg::data_t   scalar;
        for (int i = 0; i < count; i++) begin
            op     = matrix_op_pkg::calc_type_t'(2'(draw_bits(2)));
            // Slots 6 and 7 change during a run
            src_a  = int'(draw_bits(3)) % 6;
            src_b  = int'(draw_bits(3)) % 6;
            scalar = draw_bits(32);
            run_op(op, src_a, src_b, scalar, 1'b0);
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        start       = 1'b0;
        op_type     = matrix_op_pkg::CALC_ADD;
        matrix_a    = '0;
        matrix_b    = '0;
        scalar_in   = '0;
        hold_off    = 1'b0;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        stall_level = 4'd4;
        next_cycle();
        next_cycle();
        rst_n = 1'b1;
        preload_memory();
        run_op(matrix_op_pkg::CALC_ADD, 0, 1, '0, 1'b0);
        run_op(matrix_op_pkg::CALC_SCALAR_MUL, 2, 0, draw_bits(32), 1'b0);
        run_op(matrix_op_pkg::CALC_TRANSPOSE, 3, 0, '0, 1'b0);
        run_op(matrix_op_pkg::CALC_SCALAR_MUL, 1, 0, draw_bits(32), 1'b1);
        // Heavy back-pressure
        stall_level = 4'd13;
        run_random_ops(10);
        $display("Verification passed");
        $finish;
    end

endmodule
